// ==== filelist.f ====
design/mipsPkg.sv
design/wbBus.sv
design/aluUnit.sv
design/regFile.sv
design/cpuCtrl.sv
design/mipsCore.sv
design/irqTimer.sv
design/dataRam.sv
design/mipsSoc.sv
tb/mipsSoc_checker.sv
tb/mipsSocTb.sv

// ==== tb/mipsSocTb.sv ====
`timescale 1ns/1ns

module mipsSocTb;
	import mipsPkg::*;

	localparam int romWords = 2048;
	localparam word_t spinPc = 32'h0000_3080;
	localparam word_t timerPreset = 32'd24;
	localparam int irqLimit = 600;
	localparam int handlerLimit = 200;
	localparam int traceLimit = 200;

	typedef struct {
		word_t pc;
		regAddr_t rd;
		word_t data;
		bit countRead;     // Timer count has run down below the preset
	} traceEntry_t;

	logic clk;
	logic rst;
	word_t instAddr;
	word_t instData;
	logic grfWe;
	regAddr_t grfAddr;
	word_t grfWdata;
	word_t wbPc;
	logic intResponse;

	word_t rom [romWords];
	traceEntry_t expected [$];
	traceEntry_t nextWrite;
	int waitCount;

	mipsSoc mipsSoc_i (
		.clk(clk),
		.rst(rst),
		.instAddr(instAddr),
		.instData(instData),
		.grfWe(grfWe),
		.grfAddr(grfAddr),
		.grfWdata(grfWdata),
		.wbPc(wbPc),
		.intResponse(intResponse)
	);

	//////////////////////////////////////////////////////////////////////
	// Instruction encoding and the program

	function automatic word_t encodeR(int rs, int rt, int rd, logic [5:0] fn);
		return {opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic word_t encodeI(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic word_t encodeJ(word_t target);
		return {opJ, target[27:2]};
	endfunction

	function automatic word_t encodeCop0(logic [4:0] rsCode, int rt, int rd, logic [5:0] fn);
		return {opCop0, rsCode, 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	task automatic storeInstruction(word_t addr, word_t inst);
		rom[(addr - resetPc) >> 2] = inst;
	endtask

	task automatic expectWrite(word_t pc, int rd, word_t data);
		expected.push_back('{pc: pc, rd: regAddr_t'(rd), data: data, countRead: 1'b0});
	endtask

	task automatic buildProgram();
		for (int i = 0; i < romWords; i++)
			rom[i] = 32'h0;
		storeInstruction(32'h3000, encodeI(opLui, 0, 1, 16'h1234));
		expectWrite(32'h3000, 1, {16'h1234, 16'h0000});
		storeInstruction(32'h3004, encodeI(opOri, 1, 1, 16'h5678));
		expectWrite(32'h3004, 1, 32'h1234_0000 | 32'h5678);
		storeInstruction(32'h3008, encodeI(opAddiu, 0, 2, 16'hfffd));
		expectWrite(32'h3008, 2, 32'hffff_fffd);     // Sign extended -3
		storeInstruction(32'h300c, encodeI(opAddiu, 0, 3, 16'h0010));
		expectWrite(32'h300c, 3, 32'h10);
		storeInstruction(32'h3010, encodeR(1, 3, 4, fnAddu));
		expectWrite(32'h3010, 4, 32'h1234_5678 + 32'h10);
		storeInstruction(32'h3014, encodeR(3, 2, 5, fnSubu));
		expectWrite(32'h3014, 5, 32'h10 - 32'hffff_fffd);
		storeInstruction(32'h3018, encodeR(1, 4, 6, fnAnd));
		expectWrite(32'h3018, 6, 32'h1234_5678 & 32'h1234_5688);
		storeInstruction(32'h301c, encodeR(5, 6, 7, fnOr));
		expectWrite(32'h301c, 7, 32'h13 | 32'h1234_5608);
		storeInstruction(32'h3020, encodeR(2, 3, 8, fnSlt));
		expectWrite(32'h3020, 8, 32'h1);       // -3 < 16 signed
		storeInstruction(32'h3024, encodeR(3, 2, 9, fnSlt));
		expectWrite(32'h3024, 9, 32'h0);
		// RAM round trip where the last store to 0x20 wins
		storeInstruction(32'h3028, encodeI(opSw, 0, 1, 16'h0020));
		storeInstruction(32'h302c, encodeI(opSw, 3, 7, 16'h0024));
		storeInstruction(32'h3030, encodeI(opLw, 0, 10, 16'h0020));
		expectWrite(32'h3030, 10, 32'h1234_5678);
		storeInstruction(32'h3034, encodeI(opLw, 3, 11, 16'h0024));
		expectWrite(32'h3034, 11, 32'h1234_561b);
		storeInstruction(32'h3038, encodeI(opSw, 0, 2, 16'h0020));
		storeInstruction(32'h303c, encodeI(opLw, 0, 12, 16'h0020));
		expectWrite(32'h303c, 12, 32'hffff_fffd);
		// Control flow
		storeInstruction(32'h3040, encodeI(opBeq, 10, 1, 16'h0001));   // Taken
		storeInstruction(32'h3044, encodeI(opAddiu, 0, 13, 16'h0bad));
		storeInstruction(32'h3048, encodeI(opAddiu, 0, 13, 16'h0001));
		expectWrite(32'h3048, 13, 32'h1);
		storeInstruction(32'h304c, encodeI(opBeq, 10, 11, 16'h0001));  // Not taken
		storeInstruction(32'h3050, encodeI(opAddiu, 0, 14, 16'h0002));
		expectWrite(32'h3050, 14, 32'h2);
		storeInstruction(32'h3054, encodeJ(32'h3060));
		storeInstruction(32'h3058, encodeI(opAddiu, 0, 15, 16'h0bad));
		storeInstruction(32'h305c, encodeI(opAddiu, 0, 15, 16'h0bad));
		storeInstruction(32'h3060, encodeI(opAddiu, 0, 15, 16'h0003));
		expectWrite(32'h3060, 15, 32'h3);
		// Timer setup before interrupts are enabled and the core spins on $20
		storeInstruction(32'h3064, encodeI(opAddiu, 0, 16, timerBase[15:0]));
		expectWrite(32'h3064, 16, timerBase);
		storeInstruction(32'h3068, encodeI(opAddiu, 0, 17, timerPreset[15:0]));
		expectWrite(32'h3068, 17, timerPreset);
		storeInstruction(32'h306c, encodeI(opSw, 16, 17, presetOffset[15:0]));
		storeInstruction(32'h3070, encodeI(opAddiu, 0, 18, 16'h0003));
		expectWrite(32'h3070, 18, 32'h3);
		storeInstruction(32'h3074, encodeI(opSw, 16, 18, ctrlOffset[15:0]));
		storeInstruction(32'h3078, encodeI(opAddiu, 0, 19, 16'h0001));
		expectWrite(32'h3078, 19, 32'h1);
		storeInstruction(32'h307c, encodeCop0(rsMtc0, 19, statusReg, 6'h00));
		storeInstruction(spinPc, encodeI(opBeq, 20, 0, 16'hffff));
		storeInstruction(32'h3084, encodeI(opAddiu, 0, 21, 16'h0055));
		storeInstruction(32'h3088, encodeJ(32'h3088));
		// Interrupt handler
		storeInstruction(handlerPc, encodeI(opLw, 16, 22, countOffset[15:0]));
		expected.push_back('{pc: handlerPc, rd: 5'd22, data: 32'h0, countRead: 1'b1});
		storeInstruction(handlerPc + 4, encodeI(opSw, 16, 0, ctrlOffset[15:0]));
		storeInstruction(handlerPc + 8, encodeCop0(rsMfc0, 23, epcReg, 6'h00));
		expectWrite(handlerPc + 8, 23, spinPc);      // Skipped fetch was the spin beq
		storeInstruction(handlerPc + 12, encodeI(opAddiu, 0, 20, 16'h0001));
		expectWrite(handlerPc + 12, 20, 32'h1);
		storeInstruction(handlerPc + 16, encodeCop0(rsMfc0, 24, statusReg, 6'h00));
		expectWrite(handlerPc + 16, 24, 32'h3);      // EXL and IE both set
		storeInstruction(handlerPc + 20, encodeCop0(rsCo, 0, 0, fnEret));
		// Beq in the spin loop now falls through
		expectWrite(32'h3084, 21, 32'h55);
	endtask

	function automatic word_t fetchWord(word_t addr);
		word_t offset;
		offset = addr - resetPc;
		if ($isunknown(addr) || addr < resetPc || (offset >> 2) >= romWords)
			return 32'h0;
		return rom[offset >> 2];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Failure reporting

	task automatic stopWithError(string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic valueMismatch(string name, word_t got, word_t exp);
		stopWithError($sformatf("ERR %s got %h expected %h", name, got, exp));
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ROM output follows the PC just after each rising edge
	always @(posedge clk) begin
		#2;
		instData <= fetchWord(instAddr);
	end

	// Register write trace
	always @(negedge clk) begin
		if (!rst && grfWe) begin
			assert (expected.size() > 0)
				else stopWithError("Register write seen after the expected trace ended");
			nextWrite = expected.pop_front();
			assert (wbPc == nextWrite.pc)
				else valueMismatch("wbPc", wbPc, nextWrite.pc);
			assert (grfAddr == nextWrite.rd)
				else valueMismatch("grfAddr", 32'(grfAddr), 32'(nextWrite.rd));
			if (nextWrite.countRead) begin
				assert (grfWdata >= 32'd1 && grfWdata < timerPreset)
					else stopWithError($sformatf("ERR grfWdata got %h outside 1..%h",
						grfWdata, timerPreset - 32'd1));
			end else begin
				assert (grfWdata == nextWrite.data)
					else valueMismatch("grfWdata", grfWdata, nextWrite.data);
			end
		end
	end

	always @(negedge clk) begin
		if (mipsSoc_i.chk.failSeen)
			stopWithError("Bound checker reported an assertion failure");
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		rst = 1'b1;
		instData = 32'h0;
		buildProgram();
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;

		waitCount = 0;
		while (!intResponse) begin
			@(negedge clk);
			waitCount++;
			if (waitCount > irqLimit)
				stopWithError("Timeout waiting for the timer interrupt to be taken");
		end

		waitCount = 0;
		while (instAddr < handlerPc) begin
			@(negedge clk);
			waitCount++;
			if (waitCount > handlerLimit)
				stopWithError("Timeout waiting for the fetch to enter the handler");
		end

		waitCount = 0;
		while (instAddr >= handlerPc) begin
			@(negedge clk);
			waitCount++;
			if (waitCount > handlerLimit)
				stopWithError("Timeout waiting for eret to leave the handler");
		end
		assert (instAddr == spinPc) else valueMismatch("instAddr", instAddr, spinPc);

		waitCount = 0;
		while (expected.size() > 0) begin
			@(negedge clk);
			waitCount++;
			if (waitCount > traceLimit)
				stopWithError("Timeout waiting for the remaining register writes");
		end

		// Stray writes after the trace would still be caught here
		repeat (20) @(negedge clk);
		if (mipsSoc_i.chk.failSeen) begin
			stopWithError("Bound checker reported an assertion failure");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

// ==== tb/mipsSoc_checker.sv ====
`timescale 1ns/1ns

module mipsSoc_checker (
	input logic clk,
	input logic rst,
	input logic ramCyc,
	input logic ramStb,
	input logic ramAck,
	input mipsPkg::word_t ramAdr,
	input logic timerCyc,
	input logic timerStb,
	input logic timerAck,
	input mipsPkg::word_t timerAdr,
	input mipsPkg::word_t instAddr,
	input logic grfWe,
	input logic intResponse,
	input logic statusIe,
	input logic statusExl
);
	import mipsPkg::*;

	bit failSeen = 1'b0;     // Set once any assertion fails

	//////////////////////////////////////////////////////////////////////
	// Wishbone classic on the RAM side

	ramAckStb: assert property (@(posedge clk) disable iff (rst) ramAck |-> ramCyc && ramStb)
		else begin
			$error("RAM ack seen without cyc and stb");
			failSeen = 1'b1;
		end

	ramAckOnce: assert property (@(posedge clk) disable iff (rst) ramAck |=> !ramAck)
		else begin
			$error("RAM ack held for more than one cycle");
			failSeen = 1'b1;
		end

	ramStbHeld: assert property (@(posedge clk) disable iff (rst)
		ramStb && !ramAck |=> ramStb && $stable(ramAdr))
		else begin
			$error("RAM stb or adr changed before ack");
			failSeen = 1'b1;
		end

	//////////////////////////////////////////////////////////////////////
	// Wishbone classic on the timer side

	timerAckStb: assert property (@(posedge clk) disable iff (rst)
		timerAck |-> timerCyc && timerStb)
		else begin
			$error("Timer ack seen without cyc and stb");
			failSeen = 1'b1;
		end

	timerAckOnce: assert property (@(posedge clk) disable iff (rst) timerAck |=> !timerAck)
		else begin
			$error("Timer ack held for more than one cycle");
			failSeen = 1'b1;
		end

	timerStbHeld: assert property (@(posedge clk) disable iff (rst)
		timerStb && !timerAck |=> timerStb && $stable(timerAdr))
		else begin
			$error("Timer stb or adr changed before ack");
			failSeen = 1'b1;
		end

	// Address decode picks one slave at a time
	oneBus: assert property (@(posedge clk) disable iff (rst) !(ramCyc && timerCyc))
		else begin
			$error("cyc high on both buses at once");
			failSeen = 1'b1;
		end

	//////////////////////////////////////////////////////////////////////
	// Trace, interrupt and reset rules

	weOnce: assert property (@(posedge clk) disable iff (rst) grfWe |=> !grfWe)
		else begin
			$error("grfWe high for more than one cycle");
			failSeen = 1'b1;
		end

	irqAllowed: assert property (@(posedge clk) disable iff (rst)
		intResponse |-> statusIe && !statusExl)
		else begin
			$error("intResponse while interrupts disabled or exception level set");
			failSeen = 1'b1;
		end

	irqOnce: assert property (@(posedge clk) disable iff (rst) intResponse |=> !intResponse)
		else begin
			$error("intResponse high for more than one cycle");
			failSeen = 1'b1;
		end

	irqVector: assert property (@(posedge clk) disable iff (rst)
		intResponse |=> instAddr == handlerPc)
		else begin
			$error("ERR instAddr got %h expected %h", $sampled(instAddr), handlerPc);
			failSeen = 1'b1;
		end

	resetQuiet: assert property (@(posedge clk)
		$past(rst) |-> !grfWe && !intResponse && !ramCyc && !timerCyc)
		else begin
			$error("Trace or bus outputs active during reset");
			failSeen = 1'b1;
		end

	resetPcSeen: assert property (@(posedge clk) $past(rst) |-> instAddr == resetPc)
		else begin
			$error("ERR instAddr got %h expected %h", $sampled(instAddr), resetPc);
			failSeen = 1'b1;
		end

endmodule

bind mipsSoc mipsSoc_checker chk (
	.clk(clk),
	.rst(rst),
	.ramCyc(ramBus.cyc),
	.ramStb(ramBus.stb),
	.ramAck(ramBus.ack),
	.ramAdr(ramBus.adr),
	.timerCyc(timerBus.cyc),
	.timerStb(timerBus.stb),
	.timerAck(timerBus.ack),
	.timerAdr(timerBus.adr),
	.instAddr(instAddr),
	.grfWe(grfWe),
	.intResponse(intResponse),
	.statusIe(core.statusIe),
	.statusExl(core.statusExl)
);

// ==== design/mipsSoc.sv ====
`timescale 1ns/1ns

module mipsSoc (
	input logic clk,
	input logic rst,
	output mipsPkg::word_t instAddr,
	input mipsPkg::word_t instData,
	output logic grfWe,
	output mipsPkg::regAddr_t grfAddr,
	output mipsPkg::word_t grfWdata,
	output mipsPkg::word_t wbPc,
	output logic intResponse
);

	logic timerIrq;

	wbBus ramBus ();
	wbBus timerBus ();

	mipsCore core (
		.clk(clk),
		.rst(rst),
		.instAddr(instAddr),
		.instData(instData),
		.hwInt(timerIrq),
		.ramBus(ramBus),
		.timerBus(timerBus),
		.grfWe(grfWe),
		.grfAddr(grfAddr),
		.grfWdata(grfWdata),
		.wbPc(wbPc),
		.intResponse(intResponse)
	);

	dataRam ram (
		.clk(clk),
		.rst(rst),
		.bus(ramBus)
	);

	// Only interrupt source in the system
	irqTimer timer (
		.clk(clk),
		.rst(rst),
		.bus(timerBus),
		.irq(timerIrq)
	);

endmodule

// ==== design/dataRam.sv ====
`timescale 1ns/1ns

module dataRam (
	input logic clk,
	input logic rst,
	wbBus.slave bus
);
	import mipsPkg::*;

	word_t mem [ramWords];
	word_t offset;
	logic [ramIdxBits-1:0] wordIdx;
	logic access;

	assign offset = bus.adr - ramBase;
	assign wordIdx = offset[ramIdxBits+1:2];     // Byte address to word index
	assign access = bus.cyc && bus.stb && !bus.ack;

	always_ff @(posedge clk) begin
		if (rst)
			bus.ack <= 1'b0;
		else
			bus.ack <= access;    // One cycle after stb
	end

	always_ff @(posedge clk) begin
		if (access) begin
			if (bus.we)
				mem[wordIdx] <= bus.datW;
			bus.datR <= mem[wordIdx];
		end
	end

endmodule

// ==== design/irqTimer.sv ====
`timescale 1ns/1ns

module irqTimer (
	input logic clk,
	input logic rst,
	wbBus.slave bus,
	output logic irq
);
	import mipsPkg::*;

	logic [1:0] ctrl;        // Bit 1 irq mask, bit 0 count enable
	word_t preset;
	word_t count;
	logic flag;
	word_t offset;
	logic access;
	logic writeCtrl;
	logic writePreset;
	logic reload;

	assign offset = bus.adr - timerBase;
	assign access = bus.cyc && bus.stb && !bus.ack;
	assign writeCtrl = access && bus.we && (offset == ctrlOffset);
	assign writePreset = access && bus.we && (offset == presetOffset);
	assign reload = ctrl[0] && !writePreset && (count <= 32'd1);

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl <= '0;
			preset <= '0;
			count <= '0;
			flag <= 1'b0;
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= access;
			if (writeCtrl)
				ctrl <= bus.datW[1:0];
			if (writePreset) begin
				preset <= bus.datW;
				count <= bus.datW;   // New preset restarts the count
			end else if (reload) begin
				count <= preset;
			end else if (ctrl[0]) begin
				count <= count - 32'd1;
			end
			if (writeCtrl)
				flag <= 1'b0;        // Ctrl write acknowledges
			else if (reload)
				flag <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			case (offset)
				ctrlOffset: bus.datR <= {30'b0, ctrl};
				presetOffset: bus.datR <= preset;
				countOffset: bus.datR <= count;
				default: bus.datR <= '0;
			endcase
		end
	end

	assign irq = flag && ctrl[1];

endmodule

// ==== design/mipsCore.sv ====
`timescale 1ns/1ns

module mipsCore (
	input logic clk,
	input logic rst,
	output mipsPkg::word_t instAddr,
	input mipsPkg::word_t instData,
	input logic hwInt,
	wbBus.master ramBus,
	wbBus.master timerBus,
	output logic grfWe,
	output mipsPkg::regAddr_t grfAddr,
	output mipsPkg::word_t grfWdata,
	output mipsPkg::word_t wbPc,
	output logic intResponse
);
	import mipsPkg::*;

	ctrlState_t state;
	aluOp_t aluOp;
	logic irLoad;
	logic opLoad;
	logic resLoad;
	logic busStart;
	logic regWrite;
	logic pcWrite;
	logic irqEnter;
	logic irqTake;

	word_t pc;
	word_t instPc;       // Address of the instruction in flight
	word_t ir;
	word_t regA;
	word_t regB;
	word_t aluRes;
	word_t mdr;
	word_t readDataA;
	word_t readDataB;
	word_t immExt;
	word_t aluB;
	word_t aluResult;
	word_t pcNext;
	word_t writeData;
	logic aluZero;
	logic [5:0] opcode;
	logic isSpecial;
	logic isCop0;
	logic isMfc0;
	logic isMtc0;
	logic isEret;
	regAddr_t destReg;

	logic statusIe;
	logic statusExl;
	logic causeIp;
	word_t epc;
	word_t cp0Read;
	logic cp0We;

	logic busPend;
	logic missAck;
	logic busReq;
	logic busAck;
	logic hitRam;
	logic hitTimer;
	word_t busAdr;
	word_t busRdata;

	cpuCtrl ctrl (
		.clk(clk),
		.rst(rst),
		.opcode(opcode),
		.funct(ir[5:0]),
		.rsField(ir[25:21]),
		.branchEqual(aluZero),
		.busAck(busAck),
		.irqTake(irqTake),
		.irLoad(irLoad),
		.opLoad(opLoad),
		.resLoad(resLoad),
		.busStart(busStart),
		.regWrite(regWrite),
		.pcWrite(pcWrite),
		.irqEnter(irqEnter),
		.aluOp(aluOp),
		.state(state)
	);

	regFile grf (
		.clk(clk),
		.rst(rst),
		.readAddrA(ir[25:21]),
		.readAddrB(ir[20:16]),
		.writeAddr(destReg),
		.writeEn(regWrite),
		.writeData(writeData),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	aluUnit alu (
		.a(regA),
		.b(aluB),
		.op(aluOp),
		.result(aluResult),
		.zero(aluZero)
	);

	//////////////////////////////////////////////////////////////////////
	// Decode and datapath

	assign opcode = ir[31:26];
	assign isSpecial = (opcode == opSpecial);
	assign isCop0 = (opcode == opCop0);
	assign isMfc0 = isCop0 && (ir[25:21] == rsMfc0);
	assign isMtc0 = isCop0 && (ir[25:21] == rsMtc0);
	assign isEret = isCop0 && (ir[25:21] == rsCo) && (ir[5:0] == fnEret);

	assign immExt = (opcode == opOri) ? {16'b0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
	assign aluB = (isSpecial || opcode == opBeq) ? regB : immExt;
	assign destReg = isSpecial ? ir[15:11] : ir[20:16];
	assign writeData = (opcode == opLw) ? mdr : (isMfc0 ? cp0Read : aluRes);

	// PC already points past the instruction once fetch is done
	always_comb begin
		if (state == stFetch)
			pcNext = pc + 32'd4;
		else if (opcode == opJ)
			pcNext = {pc[31:28], ir[25:0], 2'b00};
		else if (isEret)
			pcNext = epc;
		else
			pcNext = pc + {immExt[29:0], 2'b00};   // Taken beq
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= resetPc;
		else if (irqEnter)
			pc <= handlerPc;
		else if (pcWrite)
			pc <= pcNext;
	end

	always_ff @(posedge clk) begin
		if (irLoad) begin
			ir <= instData;
			instPc <= pc;
		end
		if (opLoad) begin
			regA <= readDataA;
			regB <= readDataB;
		end
		if (resLoad)
			aluRes <= aluResult;
		if (busAck)
			mdr <= busRdata;
	end

	//////////////////////////////////////////////////////////////////////
	// Coprocessor 0

	assign cp0We = (state == stWriteback) && isMtc0;
	assign irqTake = hwInt && statusIe && !statusExl;

	always_ff @(posedge clk) begin
		if (rst) begin
			statusIe <= 1'b0;
			statusExl <= 1'b0;
			causeIp <= 1'b0;
		end else begin
			causeIp <= hwInt;
			if (irqEnter) begin
				statusExl <= 1'b1;
			end else if (state == stExecute && isEret) begin
				statusExl <= 1'b0;
			end else if (cp0We && ir[15:11] == statusReg) begin
				statusIe <= regB[0];
				statusExl <= regB[1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (irqEnter)
			epc <= pc;      // The instruction that was not fetched
		else if (cp0We && ir[15:11] == epcReg)
			epc <= regB;
	end

	always_comb begin
		case (ir[15:11])
			statusReg: cp0Read = {30'b0, statusExl, statusIe};
			causeReg: cp0Read = {21'b0, causeIp, 10'b0};   // IP2
			epcReg: cp0Read = epc;
			default: cp0Read = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Wishbone master

	// Address is combinational in execute, registered afterwards
	assign busAdr = busPend ? aluRes : aluResult;
	assign hitRam = (busAdr >= ramBase) && (busAdr < ramEnd);
	assign hitTimer = (busAdr >= timerBase) && (busAdr < timerEnd);
	assign busReq = busStart || busPend;
	assign busAck = ramBus.ack || timerBus.ack || missAck;
	assign busRdata = hitRam ? ramBus.datR : (hitTimer ? timerBus.datR : '0);

	assign ramBus.cyc = busReq && hitRam;
	assign ramBus.stb = busReq && hitRam;
	assign ramBus.we = (opcode == opSw);
	assign ramBus.adr = busAdr;
	assign ramBus.datW = regB;

	assign timerBus.cyc = busReq && hitTimer;
	assign timerBus.stb = busReq && hitTimer;
	assign timerBus.we = (opcode == opSw);
	assign timerBus.adr = busAdr;
	assign timerBus.datW = regB;

	always_ff @(posedge clk) begin
		if (rst) begin
			busPend <= 1'b0;
			missAck <= 1'b0;
		end else begin
			if (busAck)
				busPend <= 1'b0;
			else if (busStart)
				busPend <= 1'b1;
			missAck <= busStart && !hitRam && !hitTimer;   // Unmapped completes locally
		end
	end

	// Trace
	assign instAddr = pc;
	assign grfWe = regWrite;
	assign grfAddr = destReg;
	assign grfWdata = writeData;
	assign wbPc = instPc;
	assign intResponse = irqEnter;

endmodule

// ==== design/cpuCtrl.sv ====
`timescale 1ns/1ns

module cpuCtrl (
	input logic clk,
	input logic rst,
	input logic [5:0] opcode,
	input logic [5:0] funct,
	input logic [4:0] rsField,
	input logic branchEqual,
	input logic busAck,
	input logic irqTake,
	output logic irLoad,
	output logic opLoad,
	output logic resLoad,
	output logic busStart,
	output logic regWrite,
	output logic pcWrite,
	output logic irqEnter,
	output mipsPkg::aluOp_t aluOp,
	output mipsPkg::ctrlState_t state
);
	import mipsPkg::*;

	ctrlState_t nextState;
	aluOp_t decodedOp;
	logic isAluR;
	logic isCop0;
	logic isMfc0;
	logic isEret;
	logic isMem;
	logic writesReg;

	// Instruction class
	assign isAluR = (opcode == opSpecial) && (funct inside {fnAddu, fnSubu, fnAnd, fnOr, fnSlt});
	assign isCop0 = (opcode == opCop0);
	assign isMfc0 = isCop0 && (rsField == rsMfc0);
	assign isEret = isCop0 && (rsField == rsCo) && (funct == fnEret);
	assign isMem = (opcode == opLw) || (opcode == opSw);
	assign writesReg = isAluR || isMfc0 || (opcode inside {opAddiu, opOri, opLui, opLw});

	always_comb begin
		case (opcode)
			opSpecial: begin
				case (funct)
					fnSubu: decodedOp = aluSub;
					fnAnd: decodedOp = aluAnd;
					fnOr: decodedOp = aluOr;
					fnSlt: decodedOp = aluSlt;
					default: decodedOp = aluAdd;
				endcase
			end
			opOri: decodedOp = aluOr;
			opLui: decodedOp = aluLui;
			opBeq: decodedOp = aluSub;     // Zero flag gives equality
			default: decodedOp = aluAdd;   // addiu and address calc
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= stFetch;
		else
			state <= nextState;
	end

	always_comb begin
		irLoad = 1'b0;
		opLoad = 1'b0;
		resLoad = 1'b0;
		busStart = 1'b0;
		regWrite = 1'b0;
		pcWrite = 1'b0;
		irqEnter = 1'b0;
		aluOp = aluAdd;
		nextState = state;
		case (state)
			stFetch: begin
				if (irqTake) begin
					nextState = stIrqEntry;    // Leave PC on the skipped instruction
				end else begin
					irLoad = 1'b1;
					pcWrite = 1'b1;
					nextState = stDecode;
				end
			end
			stDecode: begin
				opLoad = 1'b1;
				nextState = stExecute;
			end
			stExecute: begin
				aluOp = decodedOp;
				resLoad = 1'b1;
				if (opcode == opBeq) begin
					pcWrite = branchEqual;
					nextState = stFetch;
				end else if (opcode == opJ || isEret) begin
					pcWrite = 1'b1;
					nextState = stFetch;
				end else if (isMem) begin
					busStart = 1'b1;
					nextState = stMemory;
				end else begin
					nextState = stWriteback;
				end
			end
			stMemory: begin
				if (busAck)
					nextState = stWriteback;
			end
			stWriteback: begin
				regWrite = writesReg;
				nextState = stFetch;
			end
			stIrqEntry: begin
				irqEnter = 1'b1;
				nextState = stFetch;
			end
			default: nextState = stFetch;
		endcase
	end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ns

module regFile (
	input logic clk,
	input logic rst,
	input mipsPkg::regAddr_t readAddrA,
	input mipsPkg::regAddr_t readAddrB,
	input mipsPkg::regAddr_t writeAddr,
	input logic writeEn,
	input mipsPkg::word_t writeData,
	output mipsPkg::word_t readDataA,
	output mipsPkg::word_t readDataB
);
	import mipsPkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// $zero always reads zero
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== design/aluUnit.sv ====
`timescale 1ns/1ns

module aluUnit (
	input mipsPkg::word_t a,
	input mipsPkg::word_t b,
	input mipsPkg::aluOp_t op,
	output mipsPkg::word_t result,
	output logic zero
);
	import mipsPkg::*;

	logic lessThan;

	assign lessThan = ($signed(a) < $signed(b));

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluSlt: result = {31'b0, lessThan};
			aluLui: result = {b[15:0], 16'h0000};   // Immediate into upper half
			default: result = '0;
		endcase
	end

	// Used by beq after a subtract
	assign zero = (result == '0);

endmodule

// ==== design/wbBus.sv ====
`timescale 1ns/1ns

interface wbBus;
	import mipsPkg::*;

	logic cyc;
	logic stb;
	logic we;
	word_t adr;
	word_t datW;     // Master to slave
	word_t datR;     // Slave to master, valid with ack
	logic ack;

	modport master (
		output cyc, stb, we, adr, datW,
		input datR, ack
	);

	modport slave (
		input cyc, stb, we, adr, datW,
		output datR, ack
	);

endinterface

// ==== design/mipsPkg.sv ====
package mipsPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;

	typedef enum logic [2:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui
	} aluOp_t;

	typedef enum logic [2:0] {
		stFetch, stDecode, stExecute, stMemory, stWriteback, stIrqEntry
	} ctrlState_t;

	//////////////////////////////////////////////////////////////////////
	// Instruction encodings

	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opCop0 = 6'h10;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	// Function codes for opSpecial and eret
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;
	localparam logic [5:0] fnEret = 6'h18;

	localparam logic [4:0] rsMfc0 = 5'h00;
	localparam logic [4:0] rsMtc0 = 5'h04;
	localparam logic [4:0] rsCo = 5'h10;    // eret lives here

	//////////////////////////////////////////////////////////////////////
	// Memory map

	localparam word_t resetPc = 32'h0000_3000;
	localparam word_t handlerPc = 32'h0000_4180;
	localparam word_t ramBase = 32'h0000_0000;
	localparam int ramWords = 256;
	localparam int ramIdxBits = $clog2(ramWords);
	localparam word_t ramEnd = ramBase + 32'(ramWords * 4);
	localparam word_t timerBase = 32'h0000_7f00;
	localparam word_t ctrlOffset = 32'h0;
	localparam word_t presetOffset = 32'h4;
	localparam word_t countOffset = 32'h8;
	localparam word_t timerEnd = timerBase + countOffset + 32'h4;

	// CP0 register numbers
	localparam regAddr_t statusReg = 5'd12;
	localparam regAddr_t causeReg = 5'd13;
	localparam regAddr_t epcReg = 5'd14;

endpackage
